// File: hdl/baud_gen.sv
`timescale 1ns/1ps
`default_nettype none

module baud_gen #(
	parameter int CLKS_PER_TICK = 4 // clocks between ticks, 2 or more
) (
	input wire clk,
	input wire rstn,
	output logic b_tick
);

	localparam int CW = $clog2(CLKS_PER_TICK);

	logic [CW-1:0] cnt; // clocks left until next tick

	// free running down counter
	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			cnt <= CW'(CLKS_PER_TICK - 1);
			b_tick <= 1'b0;
		end
		else if (cnt == '0)
		begin
			cnt <= CW'(CLKS_PER_TICK - 1); // reload
			b_tick <= 1'b1; // one clock wide
		end
		else
		begin
			cnt <= cnt - 1'b1;
			b_tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: hdl/tx_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module tx_arbiter (
	input wire clk,
	input wire rstn,
	input wire ch0_valid, // one cycle strobe
	input wire [uart_pkg::DATA_BITS-1:0] ch0_data,
	input wire ch1_valid,
	input wire [uart_pkg::DATA_BITS-1:0] ch1_data,
	input wire tx_busy, // transmitter occupied
	output logic tx_start,
	output logic [uart_pkg::DATA_BITS-1:0] tx_data,
	output logic ch0_overrun, // strobe dropped on full slot
	output logic ch1_overrun
);

	logic [1:0] in_valid; // index is channel number
	logic [uart_pkg::DATA_BITS-1:0] in_data [2];
	logic [1:0] full; // slot holds a byte
	logic [uart_pkg::DATA_BITS-1:0] slot [2]; // held bytes
	logic [1:0] grant; // one hot, at most one bit
	logic [1:0] overrun;
	logic last_grant; // channel granted last time

	assign in_valid = {ch1_valid, ch0_valid};
	assign in_data[0] = ch0_data;
	assign in_data[1] = ch1_data;

	// round robin between full slots
	always_comb
	begin
		grant = 2'b00;
		if (!tx_busy)
		begin
			if (full[0] && (!full[1] || last_grant))
				grant[0] = 1'b1;
			else if (full[1])
				grant[1] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			full <= 2'b00;
			overrun <= 2'b00;
			last_grant <= 1'b1; // ch0 goes first
		end
		else
		begin
			for (int i = 0; i < 2; i++)
			begin
				// strobe refills even in the clearing cycle
				full[i] <= in_valid[i] || (full[i] && !grant[i]);
				overrun[i] <= in_valid[i] && full[i] && !grant[i]; // held byte kept
			end
			if (tx_start)
				last_grant <= grant[1];
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 2; i++)
			if (in_valid[i] && (!full[i] || grant[i]))
				slot[i] <= in_data[i];
	end

	assign tx_start = |grant; // slot cleared in the same cycle
	assign tx_data = grant[1] ? slot[1] : slot[0];
	assign ch0_overrun = overrun[0];
	assign ch1_overrun = overrun[1];

endmodule

`default_nettype wire

// File: hdl/uart_pkg.sv
`default_nettype none

package uart_pkg;

	localparam int TICKS_PER_BIT = 4; // baud ticks per serial bit
	localparam int DATA_BITS = 8; // payload bits per frame, lsb first

	// serial output phase
	typedef enum logic [2:0] {
		tx_idle_st = 3'd0, // line held high
		tx_start_st = 3'd1, // start bit, line low
		tx_data_st = 3'd2, // shifting data bits
		tx_parity_st = 3'd3, // even parity bit
		tx_stop_st = 3'd4 // stop bit, line high
	} tx_state_t;

	// serial input phase
	typedef enum logic [2:0] {
		rx_idle_st = 3'd0, // waiting for falling edge
		rx_start_st = 3'd1, // confirm start at mid bit
		rx_data_st = 3'd2, // sampling data bits
		rx_parity_st = 3'd3, // sampling parity bit
		rx_stop_st = 3'd4 // sampling stop bit
	} rx_state_t;

endpackage

`default_nettype wire

// File: hdl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
	input wire clk,
	input wire rstn,
	input wire b_tick, // baud tick
	input wire rx, // asynchronous serial line
	input wire parity_en, // expect a parity bit
	output logic rx_valid, // one cycle per frame
	output logic [uart_pkg::DATA_BITS-1:0] rx_data,
	output logic rx_parity_err,
	output logic rx_frame_err // stop sample was low
);

	localparam int TW = $clog2(uart_pkg::TICKS_PER_BIT);
	localparam int BW = $clog2(uart_pkg::DATA_BITS);

	uart_pkg::rx_state_t state_reg;
	uart_pkg::rx_state_t state_next;
	logic rx_meta; // first sync stage
	logic rx_sync; // second sync stage
	logic rx_sync_d; // for edge detect
	logic start_edge;
	logic [TW-1:0] tick_reg;
	logic [TW-1:0] tick_next;
	logic [BW-1:0] bit_reg;
	logic [BW-1:0] bit_next;
	logic [uart_pkg::DATA_BITS-1:0] shift_reg; // bits arrive lsb first
	logic [uart_pkg::DATA_BITS-1:0] shift_next;
	logic par_reg; // received parity bit
	logic par_next;
	logic valid_next;
	logic perr_next;
	logic ferr_next;
	logic tick_mid; // sample point, tick 2 of 4
	logic tick_last;

	assign start_edge = rx_sync_d && !rx_sync; // falling edge
	assign tick_mid = b_tick && (tick_reg == TW'(uart_pkg::TICKS_PER_BIT / 2 - 1));
	assign tick_last = b_tick && (tick_reg == TW'(uart_pkg::TICKS_PER_BIT - 1));

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_sync_d <= 1'b1;
			state_reg <= uart_pkg::rx_idle_st;
			tick_reg <= '0;
			bit_reg <= '0;
			rx_valid <= 1'b0;
			rx_parity_err <= 1'b0;
			rx_frame_err <= 1'b0;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_sync_d <= rx_sync;
			state_reg <= state_next;
			tick_reg <= tick_next;
			bit_reg <= bit_next;
			rx_valid <= valid_next;
			rx_parity_err <= perr_next;
			rx_frame_err <= ferr_next;
		end
	end

	always_ff @(posedge clk)
	begin
		shift_reg <= shift_next;
		par_reg <= par_next;
	end

	always_comb
	begin
		state_next = state_reg;
		bit_next = bit_reg;
		shift_next = shift_reg;
		par_next = par_reg;
		valid_next = 1'b0;
		perr_next = 1'b0;
		ferr_next = 1'b0;
		tick_next = tick_reg;
		if (b_tick)
			tick_next = tick_last ? '0 : tick_reg + 1'b1;

		case (state_reg)
		uart_pkg::rx_idle_st:
		begin
			tick_next = '0; // phase counts from the edge
			if (start_edge)
				state_next = uart_pkg::rx_start_st;
		end
		uart_pkg::rx_start_st:
			if (tick_mid && rx_sync)
				state_next = uart_pkg::rx_idle_st; // glitch, not a start bit
			else if (tick_last)
			begin
				state_next = uart_pkg::rx_data_st;
				bit_next = '0;
			end
		uart_pkg::rx_data_st:
		begin
			if (tick_mid)
				shift_next = {rx_sync, shift_reg[uart_pkg::DATA_BITS-1:1]};
			if (tick_last)
			begin
				if (bit_reg == BW'(uart_pkg::DATA_BITS - 1))
					state_next = parity_en ? uart_pkg::rx_parity_st : uart_pkg::rx_stop_st;
				else
					bit_next = bit_reg + 1'b1;
			end
		end
		uart_pkg::rx_parity_st:
		begin
			if (tick_mid)
				par_next = rx_sync;
			if (tick_last)
				state_next = uart_pkg::rx_stop_st;
		end
		uart_pkg::rx_stop_st:
			if (tick_mid)
			begin
				// report now and rearm for a back to back start edge
				state_next = uart_pkg::rx_idle_st;
				valid_next = 1'b1;
				ferr_next = !rx_sync;
				perr_next = parity_en && (par_reg != ^shift_reg); // even parity
			end
		default:
			state_next = uart_pkg::rx_idle_st;
		endcase
	end

	assign rx_data = shift_reg; // stable from last data bit to next frame

endmodule

`default_nettype wire

// File: hdl/uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_top #(
	parameter int CLKS_PER_TICK = 4 // clocks per baud tick
) (
	input wire clk,
	input wire rstn,
	input wire ch0_valid,
	input wire [uart_pkg::DATA_BITS-1:0] ch0_data,
	input wire ch1_valid,
	input wire [uart_pkg::DATA_BITS-1:0] ch1_data,
	input wire parity_en, // static while frames in flight
	input wire rx,
	output wire tx,
	output wire tx_done,
	output wire rx_valid,
	output wire [uart_pkg::DATA_BITS-1:0] rx_data,
	output wire rx_parity_err,
	output wire rx_frame_err,
	output wire ch0_overrun,
	output wire ch1_overrun
);

	wire b_tick; // shared by tx and rx
	wire tx_start;
	wire [uart_pkg::DATA_BITS-1:0] tx_data;
	wire tx_busy;

	baud_gen #(.CLKS_PER_TICK(CLKS_PER_TICK)) baud_gen0 (
		.clk(clk), .rstn(rstn), .b_tick(b_tick)
	);

	tx_arbiter tx_arbiter0 (
		.clk(clk), .rstn(rstn),
		.ch0_valid(ch0_valid), .ch0_data(ch0_data),
		.ch1_valid(ch1_valid), .ch1_data(ch1_data),
		.tx_busy(tx_busy), .tx_start(tx_start), .tx_data(tx_data),
		.ch0_overrun(ch0_overrun), .ch1_overrun(ch1_overrun)
	);

	uart_tx uart_tx0 (
		.clk(clk), .rstn(rstn), .b_tick(b_tick),
		.tx_start(tx_start), .tx_data(tx_data), .parity_en(parity_en),
		.tx(tx), .tx_busy(tx_busy), .tx_done(tx_done)
	);

	uart_rx uart_rx0 (
		.clk(clk), .rstn(rstn), .b_tick(b_tick), .rx(rx), .parity_en(parity_en),
		.rx_valid(rx_valid), .rx_data(rx_data),
		.rx_parity_err(rx_parity_err), .rx_frame_err(rx_frame_err)
	);

endmodule

`default_nettype wire

// File: hdl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input wire clk,
	input wire rstn,
	input wire b_tick, // baud tick
	input wire tx_start, // one cycle load strobe
	input wire [uart_pkg::DATA_BITS-1:0] tx_data,
	input wire parity_en, // insert even parity bit
	output logic tx, // serial line
	output logic tx_busy,
	output logic tx_done // end of stop bit
);

	localparam int TW = $clog2(uart_pkg::TICKS_PER_BIT);
	localparam int BW = $clog2(uart_pkg::DATA_BITS);

	uart_pkg::tx_state_t state_reg;
	uart_pkg::tx_state_t state_next;
	logic [TW-1:0] tick_reg; // ticks within current bit
	logic [TW-1:0] tick_next;
	logic [BW-1:0] bit_reg; // data bit index
	logic [BW-1:0] bit_next;
	logic [uart_pkg::DATA_BITS-1:0] shift_reg; // remaining data bits
	logic [uart_pkg::DATA_BITS-1:0] shift_next;
	logic par_reg; // parity of the loaded byte
	logic par_next;
	logic tx_reg; // registered line level
	logic tx_next;
	logic tick_last; // last tick of a bit

	assign tick_last = b_tick && (tick_reg == TW'(uart_pkg::TICKS_PER_BIT - 1));

	// control state
	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			state_reg <= uart_pkg::tx_idle_st;
			tick_reg <= '0;
			bit_reg <= '0;
			tx_reg <= 1'b1; // line idles high
		end
		else
		begin
			state_reg <= state_next;
			tick_reg <= tick_next;
			bit_reg <= bit_next;
			tx_reg <= tx_next;
		end
	end

	// payload
	always_ff @(posedge clk)
	begin
		shift_reg <= shift_next;
		par_reg <= par_next;
	end

	always_comb
	begin
		state_next = state_reg;
		bit_next = bit_reg;
		shift_next = shift_reg;
		par_next = par_reg;
		tx_next = tx_reg;
		tx_done = 1'b0;
		tick_next = tick_reg;
		if (b_tick)
			tick_next = tick_last ? '0 : tick_reg + 1'b1; // edges follow b_tick

		case (state_reg)
		uart_pkg::tx_idle_st:
		begin
			tx_next = 1'b1;
			tick_next = '0;
			if (tx_start)
			begin
				state_next = uart_pkg::tx_start_st;
				shift_next = tx_data;
				par_next = ^tx_data; // even parity
				tx_next = 1'b0; // start bit on next cycle
			end
		end
		uart_pkg::tx_start_st:
			if (tick_last)
			begin
				state_next = uart_pkg::tx_data_st;
				bit_next = '0;
				tx_next = shift_reg[0]; // lsb first
			end
		uart_pkg::tx_data_st:
			if (tick_last)
			begin
				shift_next = shift_reg >> 1;
				if (bit_reg == BW'(uart_pkg::DATA_BITS - 1))
				begin
					state_next = parity_en ? uart_pkg::tx_parity_st : uart_pkg::tx_stop_st;
					tx_next = parity_en ? par_reg : 1'b1;
				end
				else
				begin
					bit_next = bit_reg + 1'b1;
					tx_next = shift_reg[1]; // next bit before the shift lands
				end
			end
		uart_pkg::tx_parity_st:
			if (tick_last)
			begin
				state_next = uart_pkg::tx_stop_st;
				tx_next = 1'b1;
			end
		uart_pkg::tx_stop_st:
			if (tick_last)
			begin
				state_next = uart_pkg::tx_idle_st;
				tx_done = 1'b1;
			end
		default:
			state_next = uart_pkg::tx_idle_st;
		endcase
	end

	assign tx = tx_reg;
	assign tx_busy = (state_reg != uart_pkg::tx_idle_st); // rises the cycle after tx_start

endmodule

`default_nettype wire

// File: src.f
hdl/uart_pkg.sv
hdl/baud_gen.sv
hdl/tx_arbiter.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_top.sv
verif/uart_tb.sv

// File: verif/uart_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tb;

	localparam int CLKS_PER_TICK = 4;
	localparam int DW = uart_pkg::DATA_BITS;
	localparam int BIT_CYCLES = CLKS_PER_TICK * uart_pkg::TICKS_PER_BIT; // clocks per serial bit
	localparam int FRAME_CYCLES = (DW + 3) * BIT_CYCLES; // longest frame with parity
	localparam int FRAMES = 24; // frames over all tests
	localparam int WATCHDOG_CYCLES = FRAMES * FRAME_CYCLES * 2 + 1000;

	logic clk;
	logic rstn;
	logic ch0_valid;
	logic [DW-1:0] ch0_data;
	logic ch1_valid;
	logic [DW-1:0] ch1_data;
	logic parity_en;
	logic loop_en; // rx follows tx
	logic rx_drive; // hand built frames
	wire rx_line;
	wire tx;
	wire tx_done;
	wire rx_valid;
	wire [DW-1:0] rx_data;
	wire rx_parity_err;
	wire rx_frame_err;
	wire ch0_overrun;
	wire ch1_overrun;

	integer seed = 25;
	string test_name;
	logic [DW-1:0] exp_q [$]; // bytes in expected grant order
	int push_cnt = 0; // bytes handed to the arbiter
	int start_cnt = 0; // start bits seen on tx
	int done_cnt = 0;
	int rx_cnt = 0;
	int cyc = 0;
	int start_cyc = 0; // cycle of last tx start bit
	bit in_frame = 0;
	bit tx_prev = 1;
	bit strobed = 0; // any channel strobed yet
	bit ovr_ok = 0; // overrun pulse allowed now
	logic [DW-1:0] last_data;
	logic last_perr;
	logic last_ferr;

	assign rx_line = loop_en ? tx : rx_drive;

	uart_top #(.CLKS_PER_TICK(CLKS_PER_TICK)) dut0 (
		.clk(clk), .rstn(rstn),
		.ch0_valid(ch0_valid), .ch0_data(ch0_data),
		.ch1_valid(ch1_valid), .ch1_data(ch1_data),
		.parity_en(parity_en), .rx(rx_line), .tx(tx), .tx_done(tx_done),
		.rx_valid(rx_valid), .rx_data(rx_data),
		.rx_parity_err(rx_parity_err), .rx_frame_err(rx_frame_err),
		.ch0_overrun(ch0_overrun), .ch1_overrun(ch1_overrun)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	initial
	begin
		#(WATCHDOG_CYCLES * 20);
		$display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Regression failed");
		$fatal(1);
	end

	task automatic report_mismatch(input string what, input int expv, input int actv);
		$display("Error %s %s: expected %0h, actual %0h", test_name, what, expv, actv);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic report_problem(input string msg);
		$display("Error %s: %s", test_name, msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	function automatic logic [DW-1:0] rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[DW-1:0];
	endfunction

	// loopback byte and frame width against the model
	task automatic check_loopback();
		logic [DW-1:0] expected;
		int nbits;
		int width;
		assert (in_frame) else report_problem("rx_valid without a start bit on tx");
		assert (exp_q.size() > 0) else report_problem("rx_valid with no byte expected");
		expected = exp_q.pop_front();
		assert (rx_data == expected) else report_mismatch("rx_data", expected, rx_data);
		assert (!rx_parity_err) else report_mismatch("rx_parity_err", 0, rx_parity_err);
		assert (!rx_frame_err) else report_mismatch("rx_frame_err", 0, rx_frame_err);
		nbits = parity_en ? DW + 3 : DW + 2; // start, data, parity, stop
		width = cyc - start_cyc;
		// rx_valid lands inside the last bit
		assert (width > (nbits - 1) * BIT_CYCLES && width <= nbits * BIT_CYCLES)
		else report_mismatch("frame width in clocks", nbits * BIT_CYCLES, width);
		in_frame = 1'b0;
	endtask

	// outputs sampled mid cycle
	always @(negedge clk)
	begin
		cyc++;
		if (rstn && !strobed)
			assert (tx && !tx_done && !rx_valid && !ch0_overrun && !ch1_overrun)
			else report_problem("tx low or an output pulsed before any strobe");
		if (rstn && !ovr_ok)
			assert (!ch0_overrun && !ch1_overrun) else report_problem("unexpected overrun pulse");
		if (tx_done)
			done_cnt++;
		if (loop_en && !in_frame && tx_prev && !tx)
		begin
			in_frame = 1'b1; // start bit
			start_cyc = cyc;
			start_cnt++;
		end
		tx_prev = tx;
		if (rx_valid)
		begin
			last_data = rx_data;
			last_perr = rx_parity_err;
			last_ferr = rx_frame_err;
			rx_cnt++;
			if (loop_en)
				check_loopback();
		end
	end

	// one cycle strobe on either or both channels
	task automatic drive_strobes(input bit v0, input logic [DW-1:0] d0,
			input bit v1, input logic [DW-1:0] d1);
		@(posedge clk);
		#2;
		strobed = 1'b1;
		ch0_valid = v0;
		ch0_data = d0;
		ch1_valid = v1;
		ch1_data = d1;
		@(posedge clk);
		#2;
		ch0_valid = 1'b0;
		ch1_valid = 1'b0;
	endtask

	// strobe one byte and wait until its start bit is on tx
	task automatic send_granted(input int ch, input logic [DW-1:0] data);
		exp_q.push_back(data);
		push_cnt++;
		if (ch == 0)
			drive_strobes(1'b1, data, 1'b0, '0);
		else
			drive_strobes(1'b0, '0, 1'b1, data);
		while (start_cnt < push_cnt)
			@(negedge clk);
	endtask

	task automatic drain();
		while (done_cnt < push_cnt || exp_q.size() != 0) // every frame sent and received
			@(negedge clk);
		@(posedge clk);
		#2;
	endtask

	task automatic loopback_run(input int n);
		for (int i = 0; i < n; i++)
			send_granted(i % 2, rand_byte()); // next strobe overlaps this frame
		drain();
	endtask

	// both slots filled while busy_ch's byte is on the line
	task automatic round_robin(input int busy_ch);
		logic [DW-1:0] d_busy;
		logic [DW-1:0] d_other;
		d_busy = rand_byte();
		d_other = rand_byte();
		if (d_other == d_busy)
			d_other = ~d_busy; // order must be visible
		send_granted(busy_ch, rand_byte());
		exp_q.push_back(d_other); // not granted last so it wins
		exp_q.push_back(d_busy);
		push_cnt += 2;
		if (busy_ch == 0)
			drive_strobes(1'b1, d_busy, 1'b1, d_other);
		else
			drive_strobes(1'b1, d_other, 1'b1, d_busy);
		drain();
	endtask

	// second strobe on the full slot of channel ch
	task automatic check_overrun(input int ch);
		logic [DW-1:0] held;
		held = rand_byte();
		send_granted(ch, rand_byte());
		exp_q.push_back(held);
		push_cnt++;
		drive_strobes(ch == 0, held, ch == 1, held); // empty slot while busy
		ovr_ok = 1'b1;
		drive_strobes(ch == 0, ~held, ch == 1, ~held); // full slot drops this byte
		@(negedge clk);
		assert (ch0_overrun == (ch == 0))
		else report_mismatch("ch0_overrun", ch == 0, ch0_overrun);
		assert (ch1_overrun == (ch == 1))
		else report_mismatch("ch1_overrun", ch == 1, ch1_overrun);
		@(posedge clk);
		ovr_ok = 1'b0;
		drain(); // dropped byte would break the queue compare
	endtask

	task automatic drive_bit(input logic b);
		@(posedge clk);
		#2;
		rx_drive = b;
		repeat (BIT_CYCLES - 1) @(posedge clk);
	endtask

	// hand built frame with parity bit and optional errors
	task automatic drive_frame(input logic [DW-1:0] data, input bit flip_par,
			input logic stop_val);
		int cnt0;
		cnt0 = rx_cnt;
		drive_bit(1'b0);
		for (int i = 0; i < DW; i++)
			drive_bit(data[i]); // lsb first
		drive_bit(^data ^ flip_par);
		drive_bit(stop_val);
		while (rx_cnt == cnt0)
			@(negedge clk);
		drive_bit(1'b1); // idle
		assert (last_data == data) else report_mismatch("rx_data", data, last_data);
		assert (last_perr == flip_par) else report_mismatch("rx_parity_err", flip_par, last_perr);
		assert (last_ferr == !stop_val) else report_mismatch("rx_frame_err", !stop_val, last_ferr);
	endtask

	initial
	begin
		rstn = 1'b0;
		ch0_valid = 1'b0;
		ch0_data = '0;
		ch1_valid = 1'b0;
		ch1_data = '0;
		parity_en = 1'b0;
		loop_en = 1'b1;
		rx_drive = 1'b1;
		test_name = "after reset";
		repeat (4) @(posedge clk);
		#2;
		rstn = 1'b1;
		repeat (10) @(posedge clk); // quiet outputs checked by the monitor
		#2;
		test_name = "loopback no parity";
		loopback_run(6);
		parity_en = 1'b1; // line idle after drain
		test_name = "loopback parity";
		loopback_run(6);
		test_name = "round robin";
		round_robin(0);
		round_robin(1);
		test_name = "overrun";
		check_overrun(0);
		check_overrun(1);
		test_name = "receiver errors";
		loop_en = 1'b0;
		drive_frame(rand_byte(), 1'b1, 1'b1); // inverted parity bit
		drive_frame(rand_byte(), 1'b0, 1'b0); // low stop bit
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire
